// ==== verilog/mult_pkg.sv ====
package mult_pkg;

	// ========================================
	// widths fixed by the board
	// ========================================
	localparam int OP_W   = 9;	// two's complement switch operand
	localparam int MAG_W  = 9;	// magnitude up to 256
	localparam int PROD_W = 17;	// magnitude up to 65536

	// ========================================
	// vector types
	// ========================================
	typedef logic [OP_W-1:0]   op_t;
	typedef logic [MAG_W-1:0]  mag_t;
	typedef logic [PROD_W-1:0] prod_t;	// also the LED vector

	// operand after conversion
	typedef struct packed {
		logic	sign;
		mag_t	mag;
	} smag_t;

	// ========================================
	// control sequence
	// ========================================
	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,	// waiting for a press
		ST_LOAD = 3'd1,
		ST_RUN  = 3'd2,	// one cycle per multiplier bit
		ST_SHOW = 3'd3,
		ST_HOLD = 3'd4	// waiting for release
	} ctl_state_e;

endpackage

// ==== verilog/switch_capture.sv ====
module switch_capture
import mult_pkg::*;
#(
	parameter int SYNC_STAGES = 2
)(
	input  logic			i_clk,
	input  logic			i_rst_n,
	input  logic [2*OP_W-1:0]	i_sw,
	input  logic			i_start_n,

	output op_t			o_multiplicand,
	output op_t			o_multiplier,
	output logic			o_start_req
);

	localparam int IN_W = 2*OP_W + 1;	// switches plus the button

	logic [SYNC_STAGES-1:0][IN_W-1:0]	r_sync;
	logic [IN_W-1:0]			w_synced;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_sync <= '0;
		end else begin
			r_sync[0] <= {~i_start_n, i_sw};	// button made active high
			for (int i = 1; i < SYNC_STAGES; i++) begin
				r_sync[i] <= r_sync[i-1];
			end
		end
	end

	assign w_synced = r_sync[SYNC_STAGES-1];

	assign o_start_req    = w_synced[IN_W-1];
	assign o_multiplicand = w_synced[2*OP_W-1:OP_W];	// upper switches
	assign o_multiplier   = w_synced[OP_W-1:0];

endmodule

// ==== verilog/operand_magnitude.sv ====
module operand_magnitude
import mult_pkg::*;
(
	input  op_t	i_val,

	output smag_t	o_smag
);

	logic	w_neg;
	mag_t	w_inv;
	mag_t	w_mag;

	assign w_neg = i_val[OP_W-1];

	// two's complement negate
	// -256 wraps to 9'h100 which is 256 unsigned
	assign w_inv = ~mag_t'(i_val) + 1'b1;

	assign w_mag = w_neg ? w_inv : mag_t'(i_val);

	assign o_smag.sign = w_neg;
	assign o_smag.mag  = w_mag;

endmodule

// ==== verilog/mult_control.sv ====
module mult_control
import mult_pkg::*;
(
	input  logic	i_clk,
	input  logic	i_rst_n,
	input  logic	i_start_req,
	input  logic	i_zero,

	output logic	o_load,
	output logic	o_shift,
	output logic	o_show
);

	ctl_state_e	r_state;
	ctl_state_e	w_next;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state <= ST_IDLE;
		end else begin
			r_state <= w_next;
		end
	end

	always_comb begin
		w_next = r_state;
		case (r_state)
			ST_IDLE: begin
				if (i_start_req) begin
					w_next = ST_LOAD;
				end
			end
			ST_LOAD: w_next = ST_RUN;
			ST_RUN: begin
				if (i_zero) begin	// last set bit handled this cycle
					w_next = ST_SHOW;
				end
			end
			ST_SHOW: w_next = ST_HOLD;
			ST_HOLD: begin
				if (!i_start_req) begin	// fresh press needed
					w_next = ST_IDLE;
				end
			end
			default: w_next = ST_IDLE;
		endcase
	end

	assign o_load  = (r_state == ST_LOAD);
	assign o_shift = (r_state == ST_RUN);
	assign o_show  = (r_state == ST_SHOW);

	// ========================================
	// checks
	// ========================================
	a_load_pulse: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_load |=> !o_load
	);

	a_show_after_run: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_show |-> $past(r_state) == ST_RUN
	);

endmodule

// ==== verilog/multiplier_shift.sv ====
module multiplier_shift
import mult_pkg::*;
(
	input  logic	i_clk,
	input  logic	i_rst_n,
	input  logic	i_load,
	input  logic	i_shift,
	input  mag_t	i_mag,

	output logic	o_lsb,
	output logic	o_zero
);

	mag_t	r_mag;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_mag <= '0;
		end else if (i_load) begin
			r_mag <= i_mag;
		end else if (i_shift) begin
			r_mag <= r_mag >> 1;
		end
	end

	assign o_lsb = r_mag[0];

	// nothing left above the current bit
	// so the run can stop after this shift
	assign o_zero = (r_mag[MAG_W-1:1] == '0);

	// control never loads mid run
	a_load_shift_excl: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!(i_load && i_shift)
	);

endmodule

// ==== verilog/multiplicand_shift.sv ====
module multiplicand_shift
import mult_pkg::*;
(
	input  logic	i_clk,
	input  logic	i_rst_n,
	input  logic	i_load,
	input  logic	i_shift,
	input  mag_t	i_mag,

	output prod_t	o_val
);

	prod_t	r_val;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_val <= '0;
		end else if (i_load) begin
			r_val <= prod_t'(i_mag);	// zero extended
		end else if (i_shift) begin
			r_val <= r_val << 1;	// tracks the multiplier bit weight
		end
	end

	assign o_val = r_val;

endmodule

// ==== verilog/product_accum.sv ====
module product_accum
import mult_pkg::*;
(
	input  logic	i_clk,
	input  logic	i_rst_n,
	input  logic	i_load,
	input  logic	i_shift,
	input  logic	i_lsb,
	input  prod_t	i_addend,

	output prod_t	o_sum
);

	prod_t			r_sum;
	logic [PROD_W:0]	w_sum_ext;	// one extra bit for carry out

	assign w_sum_ext = {1'b0, r_sum} + {1'b0, i_addend};

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_sum <= '0;
		end else if (i_load) begin
			r_sum <= '0;
		end else if (i_shift && i_lsb) begin
			r_sum <= w_sum_ext[PROD_W-1:0];
		end
	end

	assign o_sum = r_sum;

	// largest product is 256 x 256
	a_no_carry: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(i_shift && i_lsb) |-> !w_sum_ext[PROD_W]
	);

endmodule

// ==== verilog/result_display.sv ====
module result_display
import mult_pkg::*;
(
	input  logic	i_clk,
	input  logic	i_rst_n,
	input  logic	i_load,
	input  logic	i_show,
	input  logic	i_sign_a,
	input  logic	i_sign_b,
	input  prod_t	i_sum,

	output prod_t	o_led,
	output logic	o_led_sign,
	output logic	o_ready
);

	logic	r_sign_a;
	logic	r_sign_b;
	prod_t	r_led;
	logic	r_led_sign;
	logic	r_ready;
	logic	w_sign;

	// operand signs as they were at load
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_sign_a <= 1'b0;
			r_sign_b <= 1'b0;
		end else if (i_load) begin
			r_sign_a <= i_sign_a;
			r_sign_b <= i_sign_b;
		end
	end

	assign w_sign = (r_sign_a ^ r_sign_b) && (i_sum != '0);	// no negative zero

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_led      <= '0;
			r_led_sign <= 1'b0;
			r_ready    <= 1'b0;
		end else begin
			if (i_show) begin
				r_led      <= i_sum;
				r_led_sign <= w_sign;
			end
			if (i_show) begin
				r_ready <= 1'b1;
			end else if (i_load) begin
				r_ready <= 1'b0;	// cleared by the next start
			end
		end
	end

	assign o_led      = r_led;
	assign o_led_sign = r_led_sign;
	assign o_ready    = r_ready;

endmodule

// ==== verilog/ms.sv ====
module ms
import mult_pkg::*;
#(
	parameter int SYNC_STAGES = 2
)(
	input  logic			i_clk,
	input  logic			i_rst_n,
	input  logic			i_start_n,
	input  logic [2*OP_W-1:0]	i_sw,

	output prod_t			o_led,
	output logic			o_led_sign,
	output logic			o_ready
);

	op_t	w_mcand_op;
	op_t	w_mlier_op;
	logic	w_start_req;
	smag_t	w_mcand;
	smag_t	w_mlier;
	logic	w_load;
	logic	w_shift;
	logic	w_show;
	logic	w_lsb;
	logic	w_zero;
	prod_t	w_mcand_val;
	prod_t	w_sum;

	switch_capture #(
		.SYNC_STAGES	(SYNC_STAGES)
	) capture_i (
		.i_clk		(i_clk),
		.i_rst_n	(i_rst_n),
		.i_sw		(i_sw),
		.i_start_n	(i_start_n),

		.o_multiplicand	(w_mcand_op),
		.o_multiplier	(w_mlier_op),
		.o_start_req	(w_start_req)
	);

	operand_magnitude mcand_mag_i (
		.i_val		(w_mcand_op),
		.o_smag		(w_mcand)
	);

	operand_magnitude mlier_mag_i (
		.i_val		(w_mlier_op),
		.o_smag		(w_mlier)
	);

	// ========================================
	// sequencing and datapath
	// ========================================
	mult_control control_i (
		.i_clk		(i_clk),
		.i_rst_n	(i_rst_n),
		.i_start_req	(w_start_req),
		.i_zero		(w_zero),

		.o_load		(w_load),
		.o_shift	(w_shift),
		.o_show		(w_show)
	);

	multiplier_shift mlier_i (
		.i_clk		(i_clk),
		.i_rst_n	(i_rst_n),
		.i_load		(w_load),
		.i_shift	(w_shift),
		.i_mag		(w_mlier.mag),

		.o_lsb		(w_lsb),
		.o_zero		(w_zero)
	);

	multiplicand_shift mcand_i (
		.i_clk		(i_clk),
		.i_rst_n	(i_rst_n),
		.i_load		(w_load),
		.i_shift	(w_shift),
		.i_mag		(w_mcand.mag),

		.o_val		(w_mcand_val)
	);

	product_accum accum_i (
		.i_clk		(i_clk),
		.i_rst_n	(i_rst_n),
		.i_load		(w_load),
		.i_shift	(w_shift),
		.i_lsb		(w_lsb),
		.i_addend	(w_mcand_val),

		.o_sum		(w_sum)
	);

	result_display display_i (
		.i_clk		(i_clk),
		.i_rst_n	(i_rst_n),
		.i_load		(w_load),
		.i_show		(w_show),
		.i_sign_a	(w_mcand.sign),
		.i_sign_b	(w_mlier.sign),
		.i_sum		(w_sum),

		.o_led		(o_led),
		.o_led_sign	(o_led_sign),
		.o_ready	(o_ready)
	);

endmodule

// ==== tb/tb_ms.sv ====
module tb_ms
import mult_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// ========================================
	// run parameters
	// ========================================
	localparam int SYNC_STAGES     = 2;
	localparam int N_MULTS         = 60;
	localparam int CYCLES_PER_MULT = 40;
	localparam int TIMEOUT_CYCLES  = N_MULTS * CYCLES_PER_MULT + 100;
	localparam int SETTLE_CYCLES   = 5;	// switches and release through the synchronizer
	localparam int MAX_LATENCY     = 16;	// press to ready, longest run
	localparam int HOLD_CYCLES     = 30;
	localparam int N_RANDOM        = 40;
	localparam int IDLE_CYCLES     = 10;

	logic		i_clk;
	logic		i_rst_n;
	logic		i_start_n;
	logic [17:0]	i_sw;

	prod_t		o_led;
	logic		o_led_sign;
	logic		o_ready;

	int		cycle_count;
	int		check_count;
	int		error_count;
	logic [31:0]	rng_state;

	ms #(
		.SYNC_STAGES	(SYNC_STAGES)
	) dut_i (
		.i_clk		(i_clk),
		.i_rst_n	(i_rst_n),
		.i_start_n	(i_start_n),
		.i_sw		(i_sw),

		.o_led		(o_led),
		.o_led_sign	(o_led_sign),
		.o_ready	(o_ready)
	);

	initial begin
		i_clk = 1'b0;
		forever begin
			#5 i_clk = ~i_clk;
		end
	end

	// watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the tests did not finish in time", cycle_count);
		$display("sim failed");
		$finish;
	end

	// ========================================
	// helpers
	// ========================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic op_t random_operand();
		rng_state = xorshift32(rng_state);
		return op_t'(rng_state[20:12]);
	endfunction

	function automatic int signed_value(input op_t v);
		return int'($signed(v));
	endfunction

	// drive and sample just after the edge
	task automatic next_cycle();
		@(posedge i_clk);
		#1;
	endtask

	task automatic check_value(
		input string		name,
		input logic [31:0]	actual,
		input logic [31:0]	expected
	);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED %s: actual %h expected %h at %0t",
				name, actual, expected, $time);
		end
	endtask

	// set the switches, press, wait for the result
	task automatic run_mult(input op_t a, input op_t b, input bit release_after);
		int waited;
		i_start_n = 1'b1;	// a fresh press needs a release first
		i_sw      = {a, b};
		repeat (SETTLE_CYCLES) next_cycle();
		i_start_n = 1'b0;
		waited    = 0;
		while (o_ready && waited <= MAX_LATENCY) begin	// old result clears at load
			next_cycle();
			waited++;
		end
		while (!o_ready && waited <= MAX_LATENCY) begin
			next_cycle();
			waited++;
		end
		if (waited > MAX_LATENCY) begin
			error_count++;
			$display("no result within %0d cycles of the press for %0d x %0d",
				MAX_LATENCY, signed_value(a), signed_value(b));
		end
		if (release_after) begin
			i_start_n = 1'b1;
		end
	endtask

	// reference from integer multiplication
	task automatic check_product(input op_t a, input op_t b);
		int		prod;
		logic [31:0]	exp_mag;
		logic [31:0]	exp_sign;
		prod     = signed_value(a) * signed_value(b);
		exp_mag  = (prod < 0) ? -prod : prod;
		exp_sign = (prod < 0) ? 32'd1 : 32'd0;
		check_value("o_ready", o_ready, 32'd1);
		check_value("o_led", o_led, exp_mag);
		check_value("o_led_sign", o_led_sign, exp_sign);
	endtask

	task automatic mult_and_check(input int a, input int b);
		op_t op_a;
		op_t op_b;
		op_a = op_t'(a);
		op_b = op_t'(b);
		run_mult(op_a, op_b, 1'b1);
		check_product(op_a, op_b);
	endtask

	// ========================================
	// directed tests
	// ========================================
	task automatic test_after_reset();
		check_value("o_ready", o_ready, 32'd0);
		check_value("o_led", o_led, 32'd0);
		check_value("o_led_sign", o_led_sign, 32'd0);
		// nothing may start without a press
		repeat (IDLE_CYCLES) begin
			next_cycle();
			check_value("o_ready", o_ready, 32'd0);
			check_value("o_led", o_led, 32'd0);
		end
	endtask

	task automatic test_positive();
		mult_and_check(3, 5);
		mult_and_check(255, 255);
		mult_and_check(1, 1);
		mult_and_check(7, 0);
	endtask

	task automatic test_mixed_signs();
		mult_and_check(-3, 5);
		mult_and_check(-7, -9);
		mult_and_check(-5, 0);	// no negative zero
	endtask

	task automatic test_extremes();
		mult_and_check(-256, -256);
		mult_and_check(255, -256);
	endtask

	task automatic test_random();
		op_t a;
		op_t b;
		for (int n = 0; n < N_RANDOM; n++) begin
			a = random_operand();
			b = random_operand();
			run_mult(a, b, 1'b1);
			check_product(a, b);
		end
	endtask

	task automatic test_held_button();
		op_t	a;
		op_t	b;
		a = op_t'(-21);
		b = op_t'(13);
		run_mult(a, b, 1'b0);	// button stays pressed
		check_product(a, b);
		repeat (HOLD_CYCLES) begin
			i_sw = {random_operand(), random_operand()};
			next_cycle();
			check_product(a, b);	// old result stays up
		end
		// release then a new press
		mult_and_check(-100, 77);
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		i_rst_n     = 1'b0;
		i_start_n   = 1'b1;
		i_sw        = '0;
		check_count = 0;
		error_count = 0;
		rng_state   = 32'd28140;

		repeat (5) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;

		test_after_reset();
		test_positive();
		test_mixed_signs();
		test_extremes();
		test_random();
		test_held_button();

		repeat (3) next_cycle();
		$display("checks: %0d  errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
verilog/mult_pkg.sv
verilog/switch_capture.sv
verilog/operand_magnitude.sv
verilog/mult_control.sv
verilog/multiplier_shift.sv
verilog/multiplicand_shift.sv
verilog/product_accum.sv
verilog/result_display.sv
verilog/ms.sv
tb/tb_ms.sv
